//--- filelist.f
+incdir+verif
logic/absorb_pkg.sv
logic/block_if.sv
logic/segment_loader.sv
logic/block_fifo.sv
logic/chunk_feeder.sv
logic/absorb_top.sv
verif/tb_absorb_top.sv

//--- verif/absorb_tasks.svh
`ifndef ABSORB_TASKS_SVH
`define ABSORB_TASKS_SVH

function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Pad location wins over a valid byte
function automatic logic [31:0] pad_word(input logic [31:0] w, input logic [3:0] vb,
                                         input logic [3:0] pl);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
        r[8*i +: 8] = pl[i] ? 8'h01 : (vb[i] ? w[8*i +: 8] : 8'h00);
    end
    return r;
endfunction

function automatic logic [127:0] swap_block(input logic [127:0] b);
    logic [127:0] r;
    for (int i = 0; i < 16; i++) begin
        r[8*i +: 8] = b[127-8*i -: 8];
    end
    return r;
endfunction

// --------------------
// Block driver and reference
// --------------------
task automatic send_block(input bdi_type_e t, input logic eoi, input int n,
                          input logic [127:0] words, input logic [3:0] last_vb,
                          input logic [3:0] last_pl, input logic eot);
    logic [127:0] blk;
    logic [139:0] frame;
    logic [1:0]   dom;
    logic [3:0]   vb;
    logic [3:0]   pl;
    blk = '0;
    for (int i = 0; i < n; i++) begin
        vb = (i == n - 1) ? last_vb : 4'hf;
        pl = (i == n - 1) ? last_pl : 4'h0;
        blk[127-32*i -: 32] = pad_word(words[127-32*i -: 32], vb, pl);
    end
    if (t == hdr_npub)
        dom = 2'd1;
    else if (t == hdr_ad || t == hdr_hash_msg)
        dom = 2'd2;
    else
        dom = 2'd3;
    frame = {8'h00, dom, eoi || (t == hdr_hash_msg), !last_vb[0], swap_block(blk)};
    for (int k = 0; k < 14; k++) begin
        exp_q.push_back({k == 13, frame[10*k +: 10]});
    end
    for (int i = 0; i < n; i++) begin
        bdi <= words[127-32*i -: 32];
        bdi_valid <= 1'b1;
        bdi_valid_bytes <= (i == n - 1) ? last_vb : 4'hf;
        bdi_pad_loc <= (i == n - 1) ? last_pl : 4'h0;
        bdi_eot <= (i == n - 1) && eot;
        bdi_eoi <= eoi;
        bdi_type <= t;
        @(posedge clk);
        while (!bdi_ready) @(posedge clk);
    end
endtask

task automatic wait_drain();
    bdi_valid <= 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
endtask

task automatic report_test(input string name, input int errors_before);
    if (errors == errors_before) begin
        tests_passed++;
        $display("%s: ok", name);
    end else begin
        tests_failed++;
        $display("%s: FAILED with %0d errors", name, errors - errors_before);
    end
endtask

function automatic logic [127:0] random_words();
    return {next_random(), next_random(), next_random(), next_random()};
endfunction

// --------------------
// Directed tests
// --------------------
task automatic full_npub_block();
    int e0;
    e0 = errors;
    send_block(hdr_npub, 1'b0, 4, 128'h00112233_44556677_8899aabb_ccddeeff, 4'hf, 4'h0, 1'b0);
    wait_drain();
    report_test("full npub block", e0);
endtask

task automatic partial_pt_block();
    int e0;
    e0 = errors;
    send_block(hdr_pt, 1'b1, 2, {64'hdeadbeef_a1b2c3d4, 64'h0}, 4'b1100, 4'b0010, 1'b1);
    wait_drain();
    report_test("partial pt block", e0);
endtask

task automatic domain_selection();
    int e0;
    e0 = errors;
    send_block(hdr_ad, 1'b0, 4, random_words(), 4'hf, 4'h0, 1'b0);
    wait_drain();
    send_block(hdr_hash_msg, 1'b0, 4, random_words(), 4'hf, 4'h0, 1'b0);
    wait_drain();
    send_block(hdr_ct, 1'b0, 4, random_words(), 4'hf, 4'h0, 1'b0);
    wait_drain();
    report_test("domain selection", e0);
endtask

task automatic mix_backpressure();
    int e0;
    e0 = errors;
    stall_en = 1'b1;
    send_block(hdr_pt, 1'b0, 4, random_words(), 4'hf, 4'h0, 1'b0);
    wait_drain();
    stall_en = 1'b0;
    report_test("mix back-pressure", e0);
endtask

task automatic block_streaming();
    int e0;
    bdi_type_e types [4];
    types = '{hdr_ad, hdr_pt, hdr_ct, hdr_npub};
    e0 = errors;
    stall_en = 1'b1;
    saw_backpressure = 1'b0;
    for (int b = 0; b < 6; b++) begin
        send_block(types[next_random() % 4], (next_random() & 32'h1) != 0, 4,
                   random_words(), 4'hf, 4'h0, 1'b0);
    end
    wait_drain();
    stall_en = 1'b0;
    assert (saw_backpressure) else begin
        $display("bdi_ready never dropped while the block buffer was full");
        errors++;
    end
    report_test("block streaming", e0);
endtask

`endif

//--- verif/tb_absorb_top.sv
`timescale 1ns/1ps

module tb_absorb_top;
    import absorb_pkg::*;

    // 12 blocks over all tests, 20 cycles each, times 4 for margin
    localparam int block_count = 12;
    localparam int cycle_limit = block_count * 20 * 4;
    localparam logic [31:0] seed = 32'he6acc2be;

    logic                   clk;
    logic                   rst;
    logic [bus_width-1:0]   bdi;
    logic                   bdi_valid;
    logic                   bdi_ready;
    logic [bus_bytes-1:0]   bdi_pad_loc;
    logic [bus_bytes-1:0]   bdi_valid_bytes;
    logic                   bdi_eot;
    logic                   bdi_eoi;
    bdi_type_e              bdi_type;
    logic [chunk_width-1:0] mix_d;
    logic                   mix_valid;
    logic                   mix_last;
    logic                   mix_ready;

    logic [31:0]            rng_state = seed;
    logic [chunk_width:0]   exp_q [$];
    logic [chunk_width:0]   exp_entry;
    logic                   stall_en;
    logic                   saw_backpressure;
    int                     errors;
    int                     tests_passed;
    int                     tests_failed;
    int                     cycles;

    `include "absorb_tasks.svh"

    absorb_top #(
        .FIFO_DEPTH (2)
    ) DUT (
        .clk             (clk),
        .rst             (rst),
        .bdi             (bdi),
        .bdi_valid       (bdi_valid),
        .bdi_ready       (bdi_ready),
        .bdi_pad_loc     (bdi_pad_loc),
        .bdi_valid_bytes (bdi_valid_bytes),
        .bdi_eot         (bdi_eot),
        .bdi_eoi         (bdi_eoi),
        .bdi_type        (bdi_type),
        .mix_d           (mix_d),
        .mix_valid       (mix_valid),
        .mix_last        (mix_last),
        .mix_ready       (mix_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        rst = 1'b1;
        bdi = '0;
        bdi_valid = 1'b0;
        bdi_pad_loc = '0;
        bdi_valid_bytes = '0;
        bdi_eot = 1'b0;
        bdi_eoi = 1'b0;
        bdi_type = hdr_ad;
        mix_ready = 1'b1;
        stall_en = 1'b0;
        saw_backpressure = 1'b0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        full_npub_block();
        partial_pt_block();
        domain_selection();
        mix_backpressure();
        block_streaming();

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit + 10) begin
            $display("timeout after %0d cycles with %0d chunks outstanding",
                     cycles, exp_q.size());
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Random gaps on mix_ready
    always @(posedge clk) begin
        if (stall_en)
            mix_ready <= (next_random() & 32'h3) != 0;
        else
            mix_ready <= 1'b1;
    end

    always @(posedge clk) begin
        if (!rst && bdi_valid && !bdi_ready && DUT.u_fifo.full)
            saw_backpressure = 1'b1;
    end

    // --------------------
    // Chunk monitor
    // --------------------
    // A stalled chunk must already show the next expected value
    always @(posedge clk) begin
        if (!rst && mix_valid) begin
            if (exp_q.size() == 0) begin
                $display("chunk offered with no block expected");
                errors++;
            end else begin
                if (mix_ready)
                    exp_entry = exp_q.pop_front();
                else
                    exp_entry = exp_q[0];
                assert (mix_d == exp_entry[chunk_width-1:0]) else begin
                    $display("mismatch mix_d: got %h expected %h",
                             mix_d, exp_entry[chunk_width-1:0]);
                    errors++;
                end
                assert (mix_last == exp_entry[chunk_width]) else begin
                    $display("mismatch mix_last: got %h expected %h",
                             mix_last, exp_entry[chunk_width]);
                    errors++;
                end
            end
        end
    end

endmodule

//--- logic/absorb_top.sv
`timescale 1ns/1ps

module absorb_top #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                               clk,
    input  logic                               rst,

    // --------------------
    // Segment input bus
    // --------------------
    input  logic [absorb_pkg::bus_width-1:0]   bdi,
    input  logic                               bdi_valid,
    output logic                               bdi_ready,
    input  logic [absorb_pkg::bus_bytes-1:0]   bdi_pad_loc,
    input  logic [absorb_pkg::bus_bytes-1:0]   bdi_valid_bytes,
    input  logic                               bdi_eot,
    input  logic                               bdi_eoi,
    input  absorb_pkg::bdi_type_e              bdi_type,

    // --------------------
    // Mix chunk output
    // --------------------
    output logic [absorb_pkg::chunk_width-1:0] mix_d,
    output logic                               mix_valid,
    output logic                               mix_last,
    input  logic                               mix_ready
);

    // Loader to buffer, buffer to feeder
    block_if to_fifo ();
    block_if to_feeder ();

    segment_loader u_loader (
        .clk             (clk),
        .rst             (rst),
        .bdi             (bdi),
        .bdi_valid       (bdi_valid),
        .bdi_ready       (bdi_ready),
        .bdi_pad_loc     (bdi_pad_loc),
        .bdi_valid_bytes (bdi_valid_bytes),
        .bdi_eot         (bdi_eot),
        .bdi_eoi         (bdi_eoi),
        .bdi_type        (bdi_type),
        .blk             (to_fifo.source)
    );

    block_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk (clk),
        .rst (rst),
        .wr  (to_fifo.sink),
        .rd  (to_feeder.source)
    );

    chunk_feeder u_feeder (
        .clk       (clk),
        .rst       (rst),
        .blk       (to_feeder.sink),
        .mix_d     (mix_d),
        .mix_valid (mix_valid),
        .mix_last  (mix_last),
        .mix_ready (mix_ready)
    );

endmodule

//--- logic/chunk_feeder.sv
`timescale 1ns/1ps

module chunk_feeder (
    input  logic                               clk,
    input  logic                               rst,
    block_if.sink                              blk,
    output logic [absorb_pkg::chunk_width-1:0] mix_d,
    output logic                               mix_valid,
    output logic                               mix_last,
    input  logic                               mix_ready
);
    import absorb_pkg::*;

    localparam int tagged_width = block_width + 4;
    localparam int frame_width  = chunks_per_block * chunk_width;
    localparam int idx_width    = $clog2(chunks_per_block);

    typedef enum logic [1:0] {
        idle,
        ack_hold,
        feed
    } state_e;

    state_e                  state;
    logic [idx_width-1:0]    chunk_idx;
    logic [tagged_width-1:0] tagged_r;
    logic [frame_width-1:0]  frame;
    logic                    last_chunk;

    assign last_chunk = (chunk_idx == idx_width'(chunks_per_block - 1));

    // --------------------
    // Handshake and chunk counter
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            chunk_idx <= '0;
        end else begin
            case (state)
                idle: begin
                    if (blk.req)
                        state <= ack_hold;
                end
                ack_hold: begin
                    // Feeding starts once the source drops req
                    if (!blk.req)
                        state <= feed;
                end
                feed: begin
                    if (mix_ready) begin
                        if (last_chunk) begin
                            state     <= idle;
                            chunk_idx <= '0;
                        end else begin
                            chunk_idx <= chunk_idx + 1'b1;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Domain, final and pad sit above the byte-swapped block
    always_ff @(posedge clk) begin
        if (state == idle && blk.req)
            tagged_r <= {blk.domain, blk.final_flag, blk.pad, swap_bytes(blk.data)};
    end

    // --------------------
    // Chunk select
    // --------------------
    // Top chunk holds zeros above the two domain bits
    assign frame = {{(frame_width - tagged_width){1'b0}}, tagged_r};

    assign mix_d     = frame[chunk_idx*chunk_width +: chunk_width];
    assign mix_valid = (state == feed);
    assign mix_last  = mix_valid && last_chunk;
    assign blk.ack   = (state == ack_hold);

endmodule

//--- logic/block_fifo.sv
`timescale 1ns/1ps

module block_fifo #(
    parameter int DEPTH = 2
) (
    input  logic    clk,
    input  logic    rst,
    block_if.sink   wr,
    block_if.source rd
);
    import absorb_pkg::*;

    localparam int ptr_width = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_width = $clog2(DEPTH + 1);

    typedef enum logic [1:0] {
        rd_idle,
        rd_offer,
        rd_release
    } rd_phase_e;

    logic [block_width-1:0] mem_data  [DEPTH];
    logic                   mem_pad   [DEPTH];
    logic                   mem_final [DEPTH];
    domain_e                mem_dom   [DEPTH];

    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [cnt_width-1:0]   count;
    logic                   wr_ack_r;
    rd_phase_e              rd_phase;
    logic                   full;
    logic                   push;
    logic                   pop;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] p);
        if (p == ptr_width'(DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign full = (count == cnt_width'(DEPTH));
    // No ack while full, which stalls the loader
    assign push = wr.req && !wr_ack_r && !full;
    assign pop  = (rd_phase == rd_offer) && rd.ack;

    // --------------------
    // Pointers and handshakes
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            wr_ack_r <= 1'b0;
            rd_phase <= rd_idle;
        end else begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);

            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;

            if (push)
                wr_ack_r <= 1'b1;
            else if (wr_ack_r && !wr.req)
                wr_ack_r <= 1'b0;

            case (rd_phase)
                rd_idle:    if (count != '0) rd_phase <= rd_offer;
                rd_offer:   if (rd.ack) rd_phase <= rd_release;
                rd_release: if (!rd.ack) rd_phase <= rd_idle;
                default:    rd_phase <= rd_idle;
            endcase
        end
    end

    // Block storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem_data[wr_ptr]  <= wr.data;
            mem_pad[wr_ptr]   <= wr.pad;
            mem_final[wr_ptr] <= wr.final_flag;
            mem_dom[wr_ptr]   <= wr.domain;
        end
    end

    assign wr.ack        = wr_ack_r;
    assign rd.req        = (rd_phase == rd_offer);
    assign rd.data       = mem_data[rd_ptr];
    assign rd.pad        = mem_pad[rd_ptr];
    assign rd.final_flag = mem_final[rd_ptr];
    assign rd.domain     = mem_dom[rd_ptr];

endmodule

//--- logic/segment_loader.sv
`timescale 1ns/1ps

module segment_loader (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [absorb_pkg::bus_width-1:0] bdi,
    input  logic                             bdi_valid,
    output logic                             bdi_ready,
    input  logic [absorb_pkg::bus_bytes-1:0] bdi_pad_loc,
    input  logic [absorb_pkg::bus_bytes-1:0] bdi_valid_bytes,
    input  logic                             bdi_eot,
    input  logic                             bdi_eoi,
    input  absorb_pkg::bdi_type_e            bdi_type,
    block_if.source                          blk
);
    import absorb_pkg::*;

    localparam int cnt_width = $clog2(words_per_block);

    typedef enum logic [1:0] {
        load,
        pad_fill,
        offer,
        wait_ack
    } state_e;

    state_e                 state;
    state_e                 state_nxt;
    logic [cnt_width-1:0]   word_cnt;
    logic [block_width-1:0] block_r;
    logic [bus_width-1:0]   word_pad;
    bdi_type_e              type_r;
    logic                   eoi_r;
    logic                   vb0_r;
    domain_e                domain_w;
    logic                   take;
    logic                   last_slot;
    logic                   close;

    // --------------------
    // Per-byte padding
    // --------------------
    always_comb begin
        for (int i = 0; i < bus_bytes; i++) begin
            if (bdi_pad_loc[i])
                word_pad[8*i +: 8] = 8'h01;
            else if (bdi_valid_bytes[i])
                word_pad[8*i +: 8] = bdi[8*i +: 8];
            else
                word_pad[8*i +: 8] = 8'h00;
        end
    end

    assign take      = bdi_valid && bdi_ready;
    assign last_slot = (word_cnt == cnt_width'(words_per_block - 1));

    // Fourth word, a short word or end of segment closes the block
    assign close     = last_slot || !bdi_valid_bytes[0] || bdi_eot;

    // --------------------
    // Load FSM
    // --------------------
    always_comb begin
        state_nxt = state;
        case (state)
            load: begin
                if (take && close)
                    state_nxt = last_slot ? offer : pad_fill;
            end
            pad_fill: begin
                if (last_slot)
                    state_nxt = offer;
            end
            offer: begin
                if (blk.ack)
                    state_nxt = wait_ack;
            end
            wait_ack: begin
                if (!blk.ack)
                    state_nxt = load;
            end
            default: state_nxt = load;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= load;
            word_cnt <= '0;
        end else begin
            state <= state_nxt;
            // Counter wraps back to zero on the last slot
            if (take || state == pad_fill)
                word_cnt <= word_cnt + 1'b1;
        end
    end

    // Block register shifts words in from the bottom
    always_ff @(posedge clk) begin
        if (take) begin
            block_r <= {block_r[block_width-bus_width-1:0], word_pad};
            type_r  <= bdi_type;
            eoi_r   <= bdi_eoi;
            vb0_r   <= bdi_valid_bytes[0];
        end else if (state == pad_fill) begin
            block_r <= {block_r[block_width-bus_width-1:0], {bus_width{1'b0}}};
        end
    end

    // --------------------
    // Domain separation
    // --------------------
    always_comb begin
        case (type_r)
            hdr_npub:             domain_w = dom_npub;
            hdr_ad, hdr_hash_msg: domain_w = dom_ad;
            default:              domain_w = dom_msg;
        endcase
    end

    assign bdi_ready      = (state == load);
    assign blk.req        = (state == offer);
    assign blk.data       = block_r;
    assign blk.pad        = ~vb0_r;
    // Hash message blocks are always final
    assign blk.final_flag = eoi_r || (type_r == hdr_hash_msg);
    assign blk.domain     = domain_w;

endmodule

//--- logic/block_if.sv
`timescale 1ns/1ps

interface block_if;
    import absorb_pkg::*;

    // Four-phase handshake pair
    logic                   req;
    logic                   ack;

    // Padded block, first stream word in the top 32 bits
    logic [block_width-1:0] data;
    logic                   pad;
    logic                   final_flag;
    domain_e                domain;

    modport source (
        output req,
        output data,
        output pad,
        output final_flag,
        output domain,
        input  ack
    );

    modport sink (
        input  req,
        input  data,
        input  pad,
        input  final_flag,
        input  domain,
        output ack
    );

endinterface

//--- logic/absorb_pkg.sv
package absorb_pkg;

    // --------------------
    // Bus and block geometry
    // --------------------
    localparam int bus_width        = 32;
    localparam int bus_bytes        = bus_width / 8;
    localparam int block_width      = 128;
    localparam int words_per_block  = block_width / bus_width;

    // Mix input chunking, block plus 4 domain bits rounded up to whole chunks
    localparam int chunk_width      = 10;
    localparam int chunks_per_block = (block_width + 4 + chunk_width - 1) / chunk_width;

    // --------------------
    // Encodings
    // --------------------

    // Segment type codes on bdi_type
    typedef enum logic [3:0] {
        hdr_ad       = 4'd1,
        hdr_pt       = 4'd4,
        hdr_ct       = 4'd5,
        hdr_hash_msg = 4'd7,
        hdr_tag      = 4'd8,
        hdr_npub     = 4'd13
    } bdi_type_e;

    // Domain code prepended to each absorbed block
    typedef enum logic [1:0] {
        dom_npub = 2'd1,
        dom_ad   = 2'd2,
        dom_msg  = 2'd3
    } domain_e;

    // Reverse byte order so the first stream byte lands in byte 0
    function automatic logic [block_width-1:0] swap_bytes(
        input logic [block_width-1:0] value
    );
        logic [block_width-1:0] swapped;
        for (int i = 0; i < block_width / 8; i++) begin
            swapped[8*i +: 8] = value[block_width-8*(i+1) +: 8];
        end
        return swapped;
    endfunction

endpackage
